/* Bender.yml */
package:
  name: autotest

sources:
  - src/autotest_pkg.sv
  - src/vector_loader.sv
  - src/result_writer.sv
  - src/test_counters.sv
  - src/autotest_ctrl.sv
  - src/autotest_top.sv
  - target: simulation
    files:
      - sim/sd_host_model.sv
      - sim/autotest_chk.sv
      - sim/tb_autotest.sv

/* list.f */
src/autotest_pkg.sv
src/vector_loader.sv
src/result_writer.sv
src/test_counters.sv
src/autotest_ctrl.sv
src/autotest_top.sv
sim/sd_host_model.sv
sim/autotest_chk.sv
sim/tb_autotest.sv

/* sim/autotest_chk.sv */
`timescale 1ns/1ps

module autotest_chk (
  input logic clk,
  input logic rst,
  input logic spi_r_block_o,
  input logic spi_r_byte_o,
  input logic spi_w_block_o,
  input logic spi_w_byte_o,
  input logic done_o
);

  logic assert_failed;

  initial assert_failed = 1'b0;

  // read and write transfers never overlap
  a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
    !((spi_r_block_o || spi_r_byte_o) && (spi_w_block_o || spi_w_byte_o)))
    else begin
      $error("read and write requests active together");
      assert_failed = 1'b1;
    end

  a_done_sticky: assert property (@(posedge clk) disable iff (rst) done_o |=> done_o)
    else begin
      $error("done_o dropped after rising");
      assert_failed = 1'b1;
    end

  a_no_read_in_reset: assert property (@(posedge clk) rst |-> !spi_r_byte_o)
    else begin
      $error("spi_r_byte_o high during reset");
      assert_failed = 1'b1;
    end

endmodule

bind autotest_ctrl autotest_chk i_autotest_chk (
  .clk, .rst, .spi_r_block_o, .spi_r_byte_o, .spi_w_block_o, .spi_w_byte_o, .done_o
);

/* sim/sd_host_model.sv */
`timescale 1ns/1ps

module sd_host_model (
  input  logic                   clk,
  input  logic                   spi_rst_i,
  input  logic                   spi_r_block_i,
  input  logic                   spi_r_byte_i,
  input  logic                   spi_w_block_i,
  input  logic                   spi_w_byte_i,
  input  autotest_pkg::sd_addr_t spi_block_addr_i,
  input  autotest_pkg::byte_t    spi_data_in_i,
  output logic                   spi_busy_o,
  output autotest_pkg::byte_t    spi_data_out_o
);

  localparam int NUM_BLOCKS = 8;
  localparam int CMD_WAIT   = 3;

  autotest_pkg::byte_t mem [NUM_BLOCKS * autotest_pkg::SD_BLOCK_BYTES];
  logic                written [NUM_BLOCKS];
  logic                open_q;
  logic                rd_pend_q;
  int                  idx_q;
  int                  wait_q;
  int                  blk;

  // card blocks from START_BLOCK on map onto the local store
  assign blk = int'(spi_block_addr_i - autotest_pkg::START_BLOCK) & (NUM_BLOCKS - 1);

  initial begin
    spi_busy_o     = 1'b0;
    spi_data_out_o = '0;
    open_q         = 1'b0;
    rd_pend_q      = 1'b0;
    idx_q          = 0;
    wait_q         = 0;
    for (int i = 0; i < NUM_BLOCKS * autotest_pkg::SD_BLOCK_BYTES; i++) begin
      mem[i] = autotest_pkg::byte_t'(i ^ (i >> 8) ^ 32'h5A);
    end
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      written[b] = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (spi_busy_o) begin
      if (wait_q > 0) begin
        wait_q <= wait_q - 1;
      end else begin
        spi_busy_o <= 1'b0;
        // read data goes out together with the falling busy
        if (rd_pend_q) begin
          spi_data_out_o <= mem[blk * autotest_pkg::SD_BLOCK_BYTES + idx_q];
          idx_q          <= idx_q + 1;
          rd_pend_q      <= 1'b0;
        end
      end
    end else if (spi_rst_i) begin
      spi_busy_o <= 1'b1;
      wait_q     <= CMD_WAIT;
    end else if (!spi_r_block_i && !spi_w_block_i) begin
      open_q <= 1'b0;
      idx_q  <= 0;
    end else if (!open_q) begin
      open_q     <= 1'b1;
      spi_busy_o <= 1'b1;
      wait_q     <= CMD_WAIT;
    end else if (spi_r_byte_i || spi_w_byte_i) begin
      spi_busy_o <= 1'b1;
      // stretch varies from byte to byte
      wait_q     <= idx_q % 3;
      rd_pend_q  <= spi_r_byte_i;
      if (spi_w_byte_i) begin
        mem[blk * autotest_pkg::SD_BLOCK_BYTES + idx_q] <= spi_data_in_i;
        written[blk] <= 1'b1;
        idx_q        <= idx_q + 1;
      end
    end
  end

endmodule

/* sim/tb_autotest.sv */
`timescale 1ns/1ps

module tb_autotest;

  localparam int NUM_ROWS = 6;
  localparam int ENC_LAT  = 5;
  localparam int DEC_LAT  = 9;
  localparam int TIMEOUT  = NUM_ROWS * (2 * autotest_pkg::SD_BLOCK_BYTES * 6 + 50);

  // per row {decrypt, expected correct, signature valid}
  localparam logic [2:0] ROW_FLAGS [NUM_ROWS] = '{
    3'b011, 3'b111, 3'b001, 3'b101, 3'b111, 3'b010
  };

  logic                   clk;
  logic                   rst;
  logic                   spi_busy;
  autotest_pkg::byte_t    spi_data_out;
  autotest_pkg::sd_addr_t spi_block_addr;
  autotest_pkg::byte_t    spi_data_in;
  logic                   spi_rst;
  logic                   spi_r_block;
  logic                   spi_r_byte;
  logic                   spi_w_block;
  logic                   spi_w_byte;
  logic                   rst_uut;
  autotest_pkg::block_t   block_uut;
  autotest_pkg::key_t     key_uut;
  logic                   encdec_uut;
  autotest_pkg::block_t   uut_result;
  logic                   end_enc;
  logic                   end_dec;
  autotest_pkg::err_cnt_t error_count;
  logic                   done;
  logic                   chk_failed;

  autotest_pkg::block_t   tbl_block [NUM_ROWS];
  autotest_pkg::key_t     tbl_key [NUM_ROWS];
  autotest_pkg::block_t   tbl_expected [NUM_ROWS];
  autotest_pkg::sd_addr_t rd_addr;
  int                     since_fall;
  int                     cycle_count;
  int                     enc_runs;
  int                     dec_runs;
  logic                   flag_seen;
  logic                   in_run;

  autotest_top i_autotest_top (
    .clk, .rst, .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
    .spi_block_addr_o(spi_block_addr), .spi_data_in_o(spi_data_in), .spi_rst_o(spi_rst),
    .spi_r_block_o(spi_r_block), .spi_r_byte_o(spi_r_byte), .spi_w_block_o(spi_w_block),
    .spi_w_byte_o(spi_w_byte), .rst_uut_o(rst_uut), .block_uut_o(block_uut),
    .key_uut_o(key_uut), .encdec_uut_o(encdec_uut), .block_uut_i(uut_result),
    .end_enc_uut_i(end_enc), .end_dec_uut_i(end_dec), .error_count_o(error_count),
    .done_o(done)
  );

  sd_host_model i_sd_host (
    .clk, .spi_rst_i(spi_rst), .spi_r_block_i(spi_r_block), .spi_r_byte_i(spi_r_byte),
    .spi_w_block_i(spi_w_block), .spi_w_byte_i(spi_w_byte),
    .spi_block_addr_i(spi_block_addr), .spi_data_in_i(spi_data_in),
    .spi_busy_o(spi_busy), .spi_data_out_o(spi_data_out)
  );

  assign chk_failed = i_autotest_top.i_autotest_ctrl.i_autotest_chk.assert_failed;

  always #10 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [79:0] actual,
                             input logic [79:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic load_vectors();
    int          base;
    logic [31:0] sig;
    for (int r = 0; r < NUM_ROWS; r++) begin
      tbl_block[r]    = {$urandom, $urandom};
      tbl_key[r]      = {16'($urandom), $urandom, $urandom};
      tbl_expected[r] = tbl_block[r] ^ tbl_key[r][63:0];
      if (!ROW_FLAGS[r][1]) tbl_expected[r] = ~tbl_expected[r];
      sig  = ROW_FLAGS[r][0] ? autotest_pkg::SIGNATURE : ~autotest_pkg::SIGNATURE;
      base = r * autotest_pkg::SD_BLOCK_BYTES;
      for (int i = 0; i < 4; i++) i_sd_host.mem[base + i] = sig[8*(3-i) +: 8];
      for (int i = 0; i < 8; i++) begin
        i_sd_host.mem[base + autotest_pkg::OFS_BLOCK + i]    = tbl_block[r][8*i +: 8];
        i_sd_host.mem[base + autotest_pkg::OFS_EXPECTED + i] = tbl_expected[r][8*i +: 8];
      end
      for (int i = 0; i < 10; i++) begin
        i_sd_host.mem[base + autotest_pkg::OFS_KEY + i] = tbl_key[r][8*i +: 8];
      end
      // upper bits of the direction byte are don't care
      i_sd_host.mem[base + autotest_pkg::OFS_ENCDEC] = {7'h50, ROW_FLAGS[r][2]};
    end
  endtask

  task automatic inspect_record(input int row);
    int          base;
    int          lat;
    logic [63:0] value;
    base = row * autotest_pkg::SD_BLOCK_BYTES;
    lat  = ROW_FLAGS[row][2] ? DEC_LAT : ENC_LAT;
    check_value($sformatf("block %0d written", row), i_sd_host.written[row], ROW_FLAGS[row][0]);
    if (!ROW_FLAGS[row][0]) return;
    for (int i = 0; i < 8; i++) value[8*i +: 8] = i_sd_host.mem[base + i];
    check_value($sformatf("block %0d result", row), value, tbl_block[row] ^ tbl_key[row][63:0]);
    for (int i = 0; i < 8; i++) value[8*i +: 8] = i_sd_host.mem[base + 8 + i];
    if (value < lat || value > lat + 2) begin
      check_value($sformatf("block %0d cycles", row), value, lat);
    end
    for (int i = 16; i < autotest_pkg::SD_BLOCK_BYTES; i++) begin
      check_value($sformatf("block %0d byte %0d", row, i), i_sd_host.mem[base + i],
                  autotest_pkg::FILL_BYTE);
    end
  endtask

  // cipher stub, end flag only for the running direction
  always @(negedge clk) begin
    if (rst_uut) begin
      since_fall <= 0;
      end_enc    <= 1'b0;
      end_dec    <= 1'b0;
    end else begin
      since_fall <= since_fall + 1;
      uut_result <= block_uut ^ key_uut[63:0];
      end_enc    <= !encdec_uut && (since_fall >= ENC_LAT);
      end_dec    <= encdec_uut && (since_fall >= DEC_LAT);
    end
  end

  always @(negedge clk) begin
    int row;
    row = int'(spi_block_addr - autotest_pkg::START_BLOCK);
    if (spi_r_block) rd_addr = spi_block_addr;
    if (spi_w_block) check_value("spi_block_addr_o", spi_block_addr, rd_addr);
    if (!rst_uut) begin
      check_value("block_uut_o", block_uut, tbl_block[row]);
      check_value("key_uut_o", key_uut, tbl_key[row]);
      check_value("encdec_uut_o", encdec_uut, ROW_FLAGS[row][2]);
      in_run = 1'b1;
      if (encdec_uut ? end_dec : end_enc) flag_seen = 1'b1;
    end else if (in_run) begin
      check_value("own end flag seen", flag_seen, 1'b1);
      if (encdec_uut) dec_runs++;
      else enc_runs++;
      in_run    = 1'b0;
      flag_seen = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      abort_run($sformatf("sequencer hung, done_o not reached in %0d cycles", cycle_count));
    end else if (chk_failed) begin
      abort_run("an assertion in autotest_chk failed");
    end
  end

  initial begin
    int mismatch_rows;
    int enc_rows;
    int dec_rows;
    clk           = 1'b0;
    rst           = 1'b1;
    uut_result    = '0;
    end_enc       = 1'b0;
    end_dec       = 1'b0;
    since_fall    = 0;
    cycle_count   = 0;
    enc_runs      = 0;
    dec_runs      = 0;
    flag_seen     = 1'b0;
    in_run        = 1'b0;
    rd_addr       = '0;
    mismatch_rows = 0;
    enc_rows      = 0;
    dec_rows      = 0;
    void'($urandom(63860));
    @(posedge clk);
    load_vectors();
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("spi_r_block_o", spi_r_block, 1'b0);
    check_value("spi_r_byte_o", spi_r_byte, 1'b0);
    check_value("spi_w_block_o", spi_w_block, 1'b0);
    check_value("spi_w_byte_o", spi_w_byte, 1'b0);
    check_value("done_o", done, 1'b0);
    check_value("error_count_o", error_count, 0);
    check_value("spi_block_addr_o", spi_block_addr, autotest_pkg::START_BLOCK);
    check_value("rst_uut_o", rst_uut, 1'b1);
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (ROW_FLAGS[r][0] && !ROW_FLAGS[r][1]) mismatch_rows++;
      if (ROW_FLAGS[r][0] && ROW_FLAGS[r][2]) dec_rows++;
      if (ROW_FLAGS[r][0] && !ROW_FLAGS[r][2]) enc_rows++;
    end
    wait (done === 1'b1);
    // done holds and the bad block is never written
    repeat (20) begin
      @(negedge clk);
      check_value("done_o", done, 1'b1);
      check_value("spi_w_block_o", spi_w_block, 1'b0);
      check_value("spi_block_addr_o", spi_block_addr, autotest_pkg::START_BLOCK + NUM_ROWS - 1);
    end
    check_value("error_count_o", error_count, mismatch_rows);
    check_value("encrypt runs", enc_runs, enc_rows);
    check_value("decrypt runs", dec_runs, dec_rows);
    for (int r = 0; r < NUM_ROWS; r++) inspect_record(r);
    if (chk_failed) begin
      abort_run("an assertion in autotest_chk failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

/* src/autotest_ctrl.sv */
`timescale 1ns/1ps

module autotest_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    spi_busy_i,
  output logic                    spi_rst_o,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output logic                    spi_w_block_o,
  output logic                    spi_w_byte_o,
  output logic                    rst_uut_o,
  input  logic                    encdec_i,
  input  logic                    end_enc_i,
  input  logic                    end_dec_i,
  input  logic                    sig_ok_i,
  input  logic                    mismatch_i,
  input  autotest_pkg::byte_pos_t byte_pos_i,
  output logic                    rd_strobe_o,
  output logic                    capture_o,
  output logic                    pos_inc_o,
  output logic                    pos_clr_o,
  output logic                    addr_inc_o,
  output logic                    run_o,
  output logic                    run_clr_o,
  output logic                    err_inc_o,
  output logic                    done_o
);

  autotest_pkg::state_t state_q;
  autotest_pkg::state_t state_d;

  // busy has risen since entering the current state
  logic busy_seen_q;
  logic cmd_done;
  logic end_flag;
  logic last_byte;

  assign cmd_done  = busy_seen_q && !spi_busy_i;
  assign end_flag  = encdec_i ? end_dec_i : end_enc_i;
  assign last_byte = (byte_pos_i ==
                      autotest_pkg::byte_pos_t'(autotest_pkg::SD_BLOCK_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= autotest_pkg::ST_SD_RST;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || (state_q != state_d)) begin
      busy_seen_q <= 1'b0;
    end else if (spi_busy_i) begin
      busy_seen_q <= 1'b1;
    end
  end

  always_comb begin
    state_d       = state_q;
    spi_rst_o     = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    spi_w_block_o = 1'b0;
    spi_w_byte_o  = 1'b0;
    rst_uut_o     = 1'b1;
    rd_strobe_o   = 1'b0;
    capture_o     = 1'b0;
    pos_inc_o     = 1'b0;
    pos_clr_o     = 1'b0;
    addr_inc_o    = 1'b0;
    run_o         = 1'b0;
    run_clr_o     = 1'b0;
    err_inc_o     = 1'b0;
    done_o        = 1'b0;

    case (state_q)
      autotest_pkg::ST_SD_RST: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) state_d = autotest_pkg::ST_IDLE;
      end
      autotest_pkg::ST_IDLE: begin
        pos_clr_o = 1'b1;
        run_clr_o = 1'b1;
        if (!spi_busy_i) state_d = autotest_pkg::ST_RD_OPEN;
      end
      autotest_pkg::ST_RD_OPEN: begin
        spi_r_block_o = 1'b1;
        if (cmd_done) state_d = autotest_pkg::ST_RD_REQ;
      end
      autotest_pkg::ST_RD_REQ: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) state_d = autotest_pkg::ST_RD_WAIT;
      end
      autotest_pkg::ST_RD_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) begin
          rd_strobe_o = 1'b1;
          pos_inc_o   = 1'b1;
          // position reaches 512 on this increment
          state_d = last_byte ? autotest_pkg::ST_SIG_CHECK : autotest_pkg::ST_RD_REQ;
        end
      end
      autotest_pkg::ST_SIG_CHECK: begin
        state_d = sig_ok_i ? autotest_pkg::ST_START : autotest_pkg::ST_FINISHED;
      end
      autotest_pkg::ST_START: begin
        rst_uut_o = 1'b0;
        state_d   = autotest_pkg::ST_WAIT_UUT;
      end
      autotest_pkg::ST_WAIT_UUT: begin
        rst_uut_o = 1'b0;
        run_o     = 1'b1;
        if (end_flag) state_d = autotest_pkg::ST_CAPTURE;
      end
      autotest_pkg::ST_CAPTURE: begin
        // uut kept out of reset so its result is still valid here
        rst_uut_o = 1'b0;
        capture_o = 1'b1;
        state_d   = autotest_pkg::ST_COMPARE;
      end
      autotest_pkg::ST_COMPARE: begin
        err_inc_o = mismatch_i;
        pos_clr_o = 1'b1;
        state_d   = autotest_pkg::ST_WR_OPEN;
      end
      autotest_pkg::ST_WR_OPEN: begin
        spi_w_block_o = 1'b1;
        if (cmd_done) state_d = autotest_pkg::ST_WR_REQ;
      end
      autotest_pkg::ST_WR_REQ: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) state_d = autotest_pkg::ST_WR_WAIT;
      end
      autotest_pkg::ST_WR_WAIT: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          pos_inc_o = 1'b1;
          state_d = last_byte ? autotest_pkg::ST_NEXT_BLOCK : autotest_pkg::ST_WR_REQ;
        end
      end
      autotest_pkg::ST_NEXT_BLOCK: begin
        addr_inc_o = 1'b1;
        state_d    = autotest_pkg::ST_IDLE;
      end
      autotest_pkg::ST_FINISHED: begin
        done_o = 1'b1;
      end
      default: begin
        state_d = autotest_pkg::ST_SD_RST;
      end
    endcase
  end

endmodule

/* src/autotest_pkg.sv */
package autotest_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [63:0] block_t;
  typedef logic [79:0] key_t;
  typedef logic [31:0] sd_addr_t;
  typedef logic [9:0]  byte_pos_t;
  typedef logic [63:0] cycles_t;
  typedef logic [31:0] err_cnt_t;

  localparam logic [31:0] SIGNATURE      = 32'hAABB_CCDD;
  localparam sd_addr_t    START_BLOCK    = 32'h0010_0000;
  localparam int          SD_BLOCK_BYTES = 512;

  // field sizes in bytes
  localparam int BLOCK_BYTES  = 8;
  localparam int KEY_BYTES    = 10;
  localparam int CYCLES_BYTES = 8;

  // read record, multi-byte fields lsb first
  localparam byte_pos_t OFS_BLOCK    = 10'd4;
  localparam byte_pos_t OFS_KEY      = 10'd12;
  localparam byte_pos_t OFS_ENCDEC   = 10'd22;
  localparam byte_pos_t OFS_EXPECTED = 10'd23;

  // write record
  localparam byte_pos_t OFS_RESULT = 10'd0;
  localparam byte_pos_t OFS_CYCLES = 10'd8;
  localparam byte_t     FILL_BYTE  = 8'hFF;

  typedef enum logic [3:0] {
    ST_SD_RST, ST_IDLE, ST_RD_OPEN, ST_RD_REQ, ST_RD_WAIT,
    ST_SIG_CHECK, ST_START, ST_WAIT_UUT, ST_CAPTURE, ST_COMPARE,
    ST_WR_OPEN, ST_WR_REQ, ST_WR_WAIT, ST_NEXT_BLOCK, ST_FINISHED
  } state_t;

endpackage

/* src/autotest_top.sv */
`timescale 1ns/1ps

module autotest_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spi_busy_i,
  input  autotest_pkg::byte_t    spi_data_out_i,
  output autotest_pkg::sd_addr_t spi_block_addr_o,
  output autotest_pkg::byte_t    spi_data_in_o,
  output logic                   spi_rst_o,
  output logic                   spi_r_block_o,
  output logic                   spi_r_byte_o,
  output logic                   spi_w_block_o,
  output logic                   spi_w_byte_o,
  output logic                   rst_uut_o,
  output autotest_pkg::block_t   block_uut_o,
  output autotest_pkg::key_t     key_uut_o,
  output logic                   encdec_uut_o,
  input  autotest_pkg::block_t   block_uut_i,
  input  logic                   end_enc_uut_i,
  input  logic                   end_dec_uut_i,
  output autotest_pkg::err_cnt_t error_count_o,
  output logic                   done_o
);

  autotest_pkg::byte_pos_t byte_pos;
  autotest_pkg::block_t    expected;
  autotest_pkg::cycles_t   cycles;
  logic sig_ok;
  logic mismatch;
  logic rd_strobe;
  logic capture;
  logic pos_inc;
  logic pos_clr;
  logic addr_inc;
  logic run;
  logic run_clr;
  logic err_inc;

  autotest_ctrl i_autotest_ctrl (
    .clk, .rst, .spi_busy_i, .spi_rst_o, .spi_r_block_o, .spi_r_byte_o,
    .spi_w_block_o, .spi_w_byte_o, .rst_uut_o,
    .encdec_i(encdec_uut_o), .end_enc_i(end_enc_uut_i), .end_dec_i(end_dec_uut_i),
    .sig_ok_i(sig_ok), .mismatch_i(mismatch), .byte_pos_i(byte_pos),
    .rd_strobe_o(rd_strobe), .capture_o(capture), .pos_inc_o(pos_inc),
    .pos_clr_o(pos_clr), .addr_inc_o(addr_inc), .run_o(run), .run_clr_o(run_clr),
    .err_inc_o(err_inc), .done_o
  );

  // operand fields are cleared together with the cycle count at block start
  vector_loader i_vector_loader (
    .clk, .clear_i(run_clr), .rd_strobe_i(rd_strobe), .byte_pos_i(byte_pos),
    .rd_byte_i(spi_data_out_i), .sig_ok_o(sig_ok), .block_o(block_uut_o),
    .key_o(key_uut_o), .encdec_o(encdec_uut_o), .expected_o(expected)
  );

  result_writer i_result_writer (
    .clk, .capture_i(capture), .result_i(block_uut_i), .expected_i(expected),
    .cycles_i(cycles), .byte_pos_i(byte_pos), .mismatch_o(mismatch),
    .wr_byte_o(spi_data_in_o)
  );

  test_counters i_test_counters (
    .clk, .rst, .pos_inc_i(pos_inc), .pos_clr_i(pos_clr), .addr_inc_i(addr_inc),
    .run_i(run), .run_clr_i(run_clr), .err_inc_i(err_inc), .byte_pos_o(byte_pos),
    .block_addr_o(spi_block_addr_o), .cycles_o(cycles), .err_count_o(error_count_o)
  );

endmodule

/* src/result_writer.sv */
`timescale 1ns/1ps

module result_writer (
  input  logic                    clk,
  input  logic                    capture_i,
  input  autotest_pkg::block_t    result_i,
  input  autotest_pkg::block_t    expected_i,
  input  autotest_pkg::cycles_t   cycles_i,
  input  autotest_pkg::byte_pos_t byte_pos_i,
  output logic                    mismatch_o,
  output autotest_pkg::byte_t     wr_byte_o
);

  autotest_pkg::block_t    result_q;
  autotest_pkg::byte_pos_t res_ofs;
  autotest_pkg::byte_pos_t cyc_ofs;
  logic                    in_res;
  logic                    in_cyc;

  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= result_i;
    end
  end

  assign mismatch_o = (result_q != expected_i);

  assign res_ofs = byte_pos_i - autotest_pkg::OFS_RESULT;
  assign cyc_ofs = byte_pos_i - autotest_pkg::OFS_CYCLES;

  assign in_res = (res_ofs < autotest_pkg::byte_pos_t'(autotest_pkg::BLOCK_BYTES));
  assign in_cyc = (cyc_ofs < autotest_pkg::byte_pos_t'(autotest_pkg::CYCLES_BYTES));

  // result first, then cycle count, rest of the record is fill
  always_comb begin
    if (in_res) begin
      wr_byte_o = result_q[8*res_ofs[2:0] +: 8];
    end else if (in_cyc) begin
      wr_byte_o = cycles_i[8*cyc_ofs[2:0] +: 8];
    end else begin
      wr_byte_o = autotest_pkg::FILL_BYTE;
    end
  end

endmodule

/* src/test_counters.sv */
`timescale 1ns/1ps

module test_counters (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    pos_inc_i,
  input  logic                    pos_clr_i,
  input  logic                    addr_inc_i,
  input  logic                    run_i,
  input  logic                    run_clr_i,
  input  logic                    err_inc_i,
  output autotest_pkg::byte_pos_t byte_pos_o,
  output autotest_pkg::sd_addr_t  block_addr_o,
  output autotest_pkg::cycles_t   cycles_o,
  output autotest_pkg::err_cnt_t  err_count_o
);

  autotest_pkg::byte_pos_t pos_q;
  autotest_pkg::sd_addr_t  addr_q;
  autotest_pkg::cycles_t   cycles_q;
  autotest_pkg::err_cnt_t  err_q;

  // byte position inside the current block
  always_ff @(posedge clk) begin
    if (rst || pos_clr_i) begin
      pos_q <= '0;
    end else if (pos_inc_i) begin
      pos_q <= pos_q + 1'b1;
    end
  end

  // sd block address, advances once per finished record
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= autotest_pkg::START_BLOCK;
    end else if (addr_inc_i) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // uut execution time
  always_ff @(posedge clk) begin
    if (rst || run_clr_i) begin
      cycles_q <= '0;
    end else if (run_i) begin
      cycles_q <= cycles_q + 1'b1;
    end
  end

  // mismatches over the whole run
  always_ff @(posedge clk) begin
    if (rst) begin
      err_q <= '0;
    end else if (err_inc_i) begin
      err_q <= err_q + 1'b1;
    end
  end

  assign byte_pos_o   = pos_q;
  assign block_addr_o = addr_q;
  assign cycles_o     = cycles_q;
  assign err_count_o  = err_q;

endmodule

/* src/vector_loader.sv */
`timescale 1ns/1ps

module vector_loader (
  input  logic                    clk,
  input  logic                    clear_i,
  input  logic                    rd_strobe_i,
  input  autotest_pkg::byte_pos_t byte_pos_i,
  input  autotest_pkg::byte_t     rd_byte_i,
  output logic                    sig_ok_o,
  output autotest_pkg::block_t    block_o,
  output autotest_pkg::key_t      key_o,
  output logic                    encdec_o,
  output autotest_pkg::block_t    expected_o
);

  logic [31:0]             sig_q;
  autotest_pkg::block_t    block_q;
  autotest_pkg::key_t      key_q;
  logic                    encdec_q;
  autotest_pkg::block_t    expected_q;

  logic [1:0]              sig_lane;
  autotest_pkg::byte_pos_t blk_ofs;
  autotest_pkg::byte_pos_t key_ofs;
  autotest_pkg::byte_pos_t exp_ofs;
  logic                    in_sig;
  logic                    in_blk;
  logic                    in_key;
  logic                    in_encdec;
  logic                    in_exp;

  // byte 0 lands in the msb of the signature
  assign sig_lane = 2'd3 - byte_pos_i[1:0];

  // offsets wrap below the field start, so one compare covers the range
  assign blk_ofs = byte_pos_i - autotest_pkg::OFS_BLOCK;
  assign key_ofs = byte_pos_i - autotest_pkg::OFS_KEY;
  assign exp_ofs = byte_pos_i - autotest_pkg::OFS_EXPECTED;

  assign in_sig    = (byte_pos_i < autotest_pkg::byte_pos_t'(4));
  assign in_blk    = (blk_ofs < autotest_pkg::byte_pos_t'(autotest_pkg::BLOCK_BYTES));
  assign in_key    = (key_ofs < autotest_pkg::byte_pos_t'(autotest_pkg::KEY_BYTES));
  assign in_encdec = (byte_pos_i == autotest_pkg::OFS_ENCDEC);
  assign in_exp    = (exp_ofs < autotest_pkg::byte_pos_t'(autotest_pkg::BLOCK_BYTES));

  always_ff @(posedge clk) begin
    if (clear_i) begin
      sig_q      <= '0;
      block_q    <= '0;
      key_q      <= '0;
      encdec_q   <= 1'b0;
      expected_q <= '0;
    end else if (rd_strobe_i) begin
      if (in_sig) begin
        sig_q[8*sig_lane +: 8] <= rd_byte_i;
      end
      if (in_blk) begin
        block_q[8*blk_ofs[2:0] +: 8] <= rd_byte_i;
      end
      if (in_key) begin
        key_q[8*key_ofs[3:0] +: 8] <= rd_byte_i;
      end
      // only bit 0 of the direction byte matters
      if (in_encdec) begin
        encdec_q <= rd_byte_i[0];
      end
      if (in_exp) begin
        expected_q[8*exp_ofs[2:0] +: 8] <= rd_byte_i;
      end
    end
  end

  assign sig_ok_o   = (sig_q == autotest_pkg::SIGNATURE);
  assign block_o    = block_q;
  assign key_o      = key_q;
  assign encdec_o   = encdec_q;
  assign expected_o = expected_q;

endmodule
